// ==== rtl/predictor_config.svh ====
`ifndef PREDICTOR_CONFIG_SVH
`define PREDICTOR_CONFIG_SVH

// fetch address width, fixed
`define PC_WIDTH 32

// pc bits [INDEX_WIDTH+1:2] index the btb and the history table
`define INDEX_WIDTH 8
`define HIST_WIDTH 4

// everything above the index and the byte offset
`define TAG_WIDTH (`PC_WIDTH - `INDEX_WIDTH - 2)

`define BTB_DEPTH (1 << `INDEX_WIDTH)
`define PHT_DEPTH (1 << `HIST_WIDTH)

`define RESET_PC 32'h0000_0000

`endif

// ==== rtl/predictorPkg.sv ====
`include "predictor_config.svh"

package predictorPkg;

    typedef logic [`PC_WIDTH-1:0] addr_t;
    typedef logic [`HIST_WIDTH-1:0] hist_t;
    typedef logic [`INDEX_WIDTH-1:0] index_t;

    // two-bit saturating counter, upper half predicts taken
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken   = 2'b01,
        weakTaken      = 2'b10,
        strongTaken    = 2'b11
    } counterState_e;

    // outcome of comparing a resolved branch with what fetch predicted
    typedef enum logic [1:0] {
        corrNone        = 2'b00,
        corrUnpredicted = 2'b01, // taken, no prediction made
        corrFalseTaken  = 2'b10,
        corrMissedTaken = 2'b11
    } correction_e;

endpackage

// ==== rtl/branchUpdateIf.sv ====
interface branchUpdateIf;
    import predictorPkg::*;

    logic  valid;  // one-cycle strobe per resolved branch
    logic  taken;
    addr_t pc;
    addr_t target;

    modport source (
        output valid,
        output taken,
        output pc,
        output target
    );

    modport sink (
        input valid,
        input taken,
        input pc,
        input target
    );

endinterface

// ==== rtl/lookupIf.sv ====
interface lookupIf;
    import predictorPkg::*;

    addr_t fetchPc;
    logic  hit;       // btb entry valid and tag matches
    addr_t target;
    hist_t history;   // local history of the fetched branch
    logic  predTaken;

    modport requester (output fetchPc, input hit, input target, input predTaken);

    modport btbResponder (input fetchPc, output hit, output target);

    modport historyResponder (input fetchPc, output history);

    // counters only need the history, not the address
    modport counterResponder (input history, output predTaken);

endinterface

// ==== rtl/branchResolver.sv ====
module branchResolver (
    input  logic                resolveBranch,
    input  logic                resolveTaken,
    input  predictorPkg::addr_t resolvePc,
    input  predictorPkg::addr_t resolveTarget,
    input  logic                carriedPred,
    input  logic                carriedPredValid,
    branchUpdateIf.source       update,
    output logic                redirect,
    output predictorPkg::addr_t redirectPc
);
    import predictorPkg::*;

    correction_e correction;

    // compare the carried prediction against the real outcome
    always_comb begin
        correction = corrNone;
        if (resolveBranch) begin
            if (!carriedPredValid && resolveTaken) begin
                correction = corrUnpredicted;
            end else if (carriedPredValid && carriedPred && !resolveTaken) begin
                correction = corrFalseTaken;
            end else if (carriedPredValid && !carriedPred && resolveTaken) begin
                correction = corrMissedTaken;
            end
        end
    end

    assign redirect = (correction != corrNone);

    // a false taken falls through, the other two go to the target
    always_comb begin
        case (correction)
            corrFalseTaken: redirectPc = resolvePc + 32'd4;
            default:        redirectPc = resolveTarget;
        endcase
    end

    // training goes out regardless of whether a redirect is needed
    assign update.valid  = resolveBranch;
    assign update.taken  = resolveTaken;
    assign update.pc     = resolvePc;
    assign update.target = resolveTarget;

endmodule

// ==== rtl/targetBuffer.sv ====
`include "predictor_config.svh"

module targetBuffer (
    input logic           clk,
    input logic           reset,
    branchUpdateIf.sink   update,
    lookupIf.btbResponder lookup
);
    import predictorPkg::*;

    logic [`BTB_DEPTH-1:0]  validBits;
    logic [`TAG_WIDTH-1:0]  tags [`BTB_DEPTH];
    addr_t                  targets [`BTB_DEPTH];

    index_t                 readIndex;
    index_t                 writeIndex;
    logic [`TAG_WIDTH-1:0]  readTag;
    logic [`TAG_WIDTH-1:0]  writeTag;

    // word aligned, so skip the two low bits
    assign readIndex  = lookup.fetchPc[`INDEX_WIDTH+1:2];
    assign readTag    = lookup.fetchPc[`PC_WIDTH-1:`INDEX_WIDTH+2];
    assign writeIndex = update.pc[`INDEX_WIDTH+1:2];
    assign writeTag   = update.pc[`PC_WIDTH-1:`INDEX_WIDTH+2];

    // lookup sees old contents during a same-cycle write
    assign lookup.hit    = validBits[readIndex] && (tags[readIndex] == readTag);
    assign lookup.target = targets[readIndex];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            validBits <= '0;
        end else if (update.valid) begin
            validBits[writeIndex] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (update.valid) begin
            tags[writeIndex]    <= writeTag; // evicts whatever shared this slot
            targets[writeIndex] <= update.target;
        end
    end

endmodule

// ==== rtl/historyTable.sv ====
`include "predictor_config.svh"

module historyTable (
    input  logic                clk,
    input  logic                reset,
    branchUpdateIf.sink         update,
    lookupIf.historyResponder   lookup,
    output predictorPkg::hist_t updateHistory
);
    import predictorPkg::*;

    hist_t  histories [`BTB_DEPTH];
    index_t readIndex;
    index_t writeIndex;

    assign readIndex  = lookup.fetchPc[`INDEX_WIDTH+1:2];
    assign writeIndex = update.pc[`INDEX_WIDTH+1:2];

    // prediction side
    assign lookup.history = histories[readIndex];

    // training side, history before the shift selects the counter
    assign updateHistory = histories[writeIndex];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `BTB_DEPTH; i++) begin
                histories[i] <= '0;
            end
        end else if (update.valid) begin
            // newest outcome enters at bit 0
            histories[writeIndex] <= {updateHistory[`HIST_WIDTH-2:0], update.taken};
        end
    end

endmodule

// ==== rtl/patternTable.sv ====
`include "predictor_config.svh"

module patternTable (
    input logic                clk,
    input logic                reset,
    branchUpdateIf.sink        update,
    input predictorPkg::hist_t updateHistory,
    lookupIf.counterResponder  lookup
);
    import predictorPkg::*;

    counterState_e counters [`PHT_DEPTH];
    counterState_e current;

    // one step toward the outcome, holding at either end
    function automatic counterState_e stepCounter(counterState_e state, logic taken);
        counterState_e result;
        result = state;
        case (state)
            strongNotTaken: result = taken ? weakNotTaken : strongNotTaken;
            weakNotTaken:   result = taken ? weakTaken : strongNotTaken;
            weakTaken:      result = taken ? strongTaken : weakNotTaken;
            strongTaken:    result = taken ? strongTaken : weakTaken;
            default:        result = weakNotTaken;
        endcase
        return result;
    endfunction

    assign current = counters[lookup.history];

    always_comb begin
        case (current)
            weakTaken, strongTaken: lookup.predTaken = 1'b1;
            default:                lookup.predTaken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `PHT_DEPTH; i++) begin
                counters[i] <= weakNotTaken; // start just below taken
            end
        end else if (update.valid) begin
            counters[updateHistory] <= stepCounter(counters[updateHistory], update.taken);
        end
    end

endmodule

// ==== rtl/nextPcSelect.sv ====
`include "predictor_config.svh"

module nextPcSelect (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                redirect,
    input  predictorPkg::addr_t redirectPc,
    lookupIf.requester          lookup,
    output predictorPkg::addr_t nextPc
);
    import predictorPkg::*;

    addr_t fetchPc;
    addr_t pcPlus4;
    addr_t predictedPc;

    // fetch address register, loads the selected next pc each edge
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            fetchPc <= `RESET_PC;
        end else begin
            fetchPc <= nextPc;
        end
    end

    assign lookup.fetchPc = fetchPc;
    assign pcPlus4        = fetchPc + 32'd4;

    // follow the btb target only on a hit predicted taken
    assign predictedPc = (lookup.hit && lookup.predTaken) ? lookup.target : pcPlus4;

    // reset, then stall, then correction, then prediction
    always_comb begin
        if (!reset) begin
            nextPc = `RESET_PC;
        end else if (stall) begin
            nextPc = fetchPc;
        end else if (redirect) begin
            nextPc = redirectPc;
        end else begin
            nextPc = predictedPc;
        end
    end

endmodule

// ==== rtl/localPredictor.sv ====
module localPredictor (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                resolveBranch,
    input  logic                resolveTaken,
    input  predictorPkg::addr_t resolvePc,
    input  predictorPkg::addr_t resolveTarget,
    input  logic                carriedPred,
    input  logic                carriedPredValid,
    output predictorPkg::addr_t nextPc,
    output predictorPkg::addr_t fetchPc,
    output logic                predTaken,
    output logic                predValid
);
    import predictorPkg::*;

    branchUpdateIf update ();
    lookupIf       lookup ();

    logic  redirect;
    addr_t redirectPc;
    hist_t updateHistory; // history of the resolving branch

    branchResolver uResolver (
        .resolveBranch    (resolveBranch),
        .resolveTaken     (resolveTaken),
        .resolvePc        (resolvePc),
        .resolveTarget    (resolveTarget),
        .carriedPred      (carriedPred),
        .carriedPredValid (carriedPredValid),
        .update           (update.source),
        .redirect         (redirect),
        .redirectPc       (redirectPc)
    );

    targetBuffer uTargetBuffer (.clk(clk), .reset(reset), .update(update.sink),
        .lookup(lookup.btbResponder));

    historyTable uHistoryTable (.clk(clk), .reset(reset), .update(update.sink),
        .lookup(lookup.historyResponder), .updateHistory(updateHistory));

    patternTable uPatternTable (.clk(clk), .reset(reset), .update(update.sink),
        .updateHistory(updateHistory), .lookup(lookup.counterResponder));

    nextPcSelect uNextPcSelect (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .lookup     (lookup.requester),
        .nextPc     (nextPc)
    );

    // prediction travels down the pipeline with the fetched instruction
    assign fetchPc   = lookup.fetchPc;
    assign predValid = lookup.hit;
    assign predTaken = lookup.predTaken;

endmodule

// ==== tests/localPredictorTb.sv ====
`include "predictor_config.svh"

module localPredictorTb;

    localparam int PERIOD = 40;
    localparam int PLANNED_CYCLES = 2200; // directed tests plus the random run
    localparam int MARGIN_CYCLES = 100;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        resolveBranch;
    logic        resolveTaken;
    logic [31:0] resolvePc;
    logic [31:0] resolveTarget;
    logic        carriedPred;
    logic        carriedPredValid;
    logic [31:0] nextPc;
    logic [31:0] fetchPc;
    logic        predTaken;
    logic        predValid;

    // reference model state
    logic [31:0]             modelFetch;
    logic                    modelBtbValid [`BTB_DEPTH];
    logic [`TAG_WIDTH-1:0]   modelBtbTag [`BTB_DEPTH];
    logic [31:0]             modelBtbTarget [`BTB_DEPTH];
    logic [`HIST_WIDTH-1:0]  modelHist [`BTB_DEPTH];
    int                      modelCounter [`PHT_DEPTH];

    // values seen at the last check point
    logic [31:0] sampledNext;
    logic        sampledPredTaken;
    logic        sampledPredValid;
    logic [31:0] checkedFetch;
    logic [31:0] checkedPredNext;

    logic [31:0] rngState;
    int          checkCount;
    int          errorCount;
    int          testCount;

    localPredictor DUT (
        .clk              (clk),
        .reset            (reset),
        .stall            (stall),
        .resolveBranch    (resolveBranch),
        .resolveTaken     (resolveTaken),
        .resolvePc        (resolvePc),
        .resolveTarget    (resolveTarget),
        .carriedPred      (carriedPred),
        .carriedPredValid (carriedPredValid),
        .nextPc           (nextPc),
        .fetchPc          (fetchPc),
        .predTaken        (predTaken),
        .predValid        (predValid)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // eight branch addresses, 0 and 1 share index 0x10 with different tags
    function automatic logic [31:0] poolPc(input int i);
        case (i)
            0: return 32'h0000_0040;
            1: return 32'h0000_0440;
            2: return 32'h0000_0100;
            3: return 32'h0000_0180;
            4: return 32'h0000_0208;
            5: return 32'h0000_0300;
            6: return 32'h0000_1024;
            default: return 32'h0000_0ffc;
        endcase
    endfunction

    // targets mostly chain to the next pool entry
    function automatic logic [31:0] poolTarget(input int i);
        case (i)
            0: return 32'h0000_0100;
            1: return 32'h0000_0180;
            2: return 32'h0000_0180;
            3: return 32'h0000_0208;
            4: return 32'h0000_0300;
            5: return 32'h0000_1024;
            6: return 32'h0000_0ffc;
            default: return 32'h0000_0040;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at time %0t: %s is %h, expected %h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic clearModel();
        modelFetch = `RESET_PC;
        for (int i = 0; i < `BTB_DEPTH; i++) begin
            modelBtbValid[i] = 1'b0;
            modelHist[i] = '0;
        end
        for (int i = 0; i < `PHT_DEPTH; i++) begin
            modelCounter[i] = 1; // weakly not taken
        end
    endtask

    // entered and left 5 units after a rising edge
    task automatic runCycle(input logic st, input logic br, input logic tk, input int pick,
                            input logic cp, input logic cpv);
        logic [31:0]            rPc;
        logic [31:0]            rTarget;
        logic [31:0]            expNext;
        logic [31:0]            predNext;
        logic [`INDEX_WIDTH-1:0] idx;
        logic [`INDEX_WIDTH-1:0] wIdx;
        logic [`HIST_WIDTH-1:0]  h;
        logic                   hit;
        logic                   predT;
        rPc = poolPc(pick);
        rTarget = poolTarget(pick);
        stall = st;
        resolveBranch = br;
        resolveTaken = tk;
        resolvePc = rPc;
        resolveTarget = rTarget;
        carriedPred = cp;
        carriedPredValid = cpv;
        #25; // 10 units before the next edge
        idx = modelFetch[`INDEX_WIDTH+1:2];
        hit = modelBtbValid[idx] && (modelBtbTag[idx] == modelFetch[31:`INDEX_WIDTH+2]);
        predT = (modelCounter[modelHist[idx]] >= 2);
        predNext = (hit && predT) ? modelBtbTarget[idx] : modelFetch + 32'd4;
        expNext = predNext;
        if (br && !cpv && tk) expNext = rTarget;          // unpredicted taken
        if (br && cpv && cp && !tk) expNext = rPc + 32'd4; // false taken
        if (br && cpv && !cp && tk) expNext = rTarget;     // missed taken
        if (st) expNext = modelFetch;
        if (!reset) expNext = `RESET_PC;
        checkValue("fetchPc", fetchPc, modelFetch);
        checkValue("nextPc", nextPc, expNext);
        checkValue("predValid", predValid, hit);
        checkValue("predTaken", predTaken, predT);
        sampledNext = nextPc;
        sampledPredTaken = predTaken;
        sampledPredValid = predValid;
        checkedFetch = modelFetch;
        checkedPredNext = predNext;
        @(posedge clk);
        if (!reset) begin
            clearModel();
        end else begin
            modelFetch = expNext;
            if (br) begin
                wIdx = rPc[`INDEX_WIDTH+1:2];
                h = modelHist[wIdx]; // old history picks the counter
                if (tk && modelCounter[h] < 3) modelCounter[h]++;
                if (!tk && modelCounter[h] > 0) modelCounter[h]--;
                modelHist[wIdx] = {h[`HIST_WIDTH-2:0], tk};
                modelBtbValid[wIdx] = 1'b1;
                modelBtbTag[wIdx] = rPc[31:`INDEX_WIDTH+2];
                modelBtbTarget[wIdx] = rTarget;
            end
        end
        #5;
    endtask

    task automatic idleCycle();
        runCycle(1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b0);
    endtask

    task automatic reportTest(input string name, input int checksBefore, input int errorsBefore);
        testCount++;
        $display("%s finished: %0d checks, %0d errors", name,
                 checkCount - checksBefore, errorCount - errorsBefore);
    endtask

    task automatic testResetSequential();
        int c0;
        int e0;
        c0 = checkCount;
        e0 = errorCount;
        for (int i = 0; i < 9; i++) begin
            idleCycle();
            checkValue("nextPc", sampledNext, `RESET_PC);
        end
        reset = 1'b1;
        for (int i = 0; i < 12; i++) begin
            idleCycle();
            checkValue("nextPc", sampledNext, checkedFetch + 32'd4);
            checkValue("predValid", sampledPredValid, 1'b0);
        end
        reportTest("reset and sequential fetch", c0, e0);
    endtask

    task automatic testStall();
        int          c0;
        int          e0;
        logic [31:0] holdPc;
        c0 = checkCount;
        e0 = errorCount;
        holdPc = modelFetch;
        for (int i = 0; i < 6; i++) begin
            // unpredicted taken branch would redirect if not stalled
            runCycle(1'b1, (i % 2 == 0), 1'b1, 5, 1'b0, 1'b0);
            checkValue("nextPc", sampledNext, holdPc);
        end
        idleCycle();
        reportTest("stall", c0, e0);
    endtask

    task automatic testCorrections();
        int c0;
        int e0;
        c0 = checkCount;
        e0 = errorCount;
        runCycle(1'b0, 1'b1, 1'b1, 4, 1'b0, 1'b0);
        checkValue("nextPc", sampledNext, poolTarget(4));
        idleCycle();
        runCycle(1'b0, 1'b1, 1'b0, 4, 1'b1, 1'b1);
        checkValue("nextPc", sampledNext, poolPc(4) + 32'd4);
        idleCycle();
        runCycle(1'b0, 1'b1, 1'b1, 4, 1'b0, 1'b1);
        checkValue("nextPc", sampledNext, poolTarget(4));
        idleCycle();
        runCycle(1'b0, 1'b1, 1'b1, 4, 1'b1, 1'b1); // correct prediction
        checkValue("nextPc", sampledNext, checkedPredNext);
        idleCycle();
        runCycle(1'b0, 1'b1, 1'b0, 4, 1'b0, 1'b0); // not taken, nothing predicted
        checkValue("nextPc", sampledNext, checkedPredNext);
        idleCycle();
        reportTest("corrections", c0, e0);
    endtask

    task automatic testTraining();
        int c0;
        int e0;
        c0 = checkCount;
        e0 = errorCount;
        for (int i = 0; i < 6; i++) begin
            runCycle(1'b0, 1'b1, 1'b1, 3, 1'b0, 1'b0);
        end
        runCycle(1'b0, 1'b1, 1'b1, 2, 1'b0, 1'b0); // lands fetch on pool pc 3
        idleCycle();
        checkValue("predValid", sampledPredValid, 1'b1);
        checkValue("predTaken", sampledPredTaken, 1'b1);
        checkValue("nextPc", sampledNext, poolTarget(3));
        // alternating outcome on pool pc 6
        for (int i = 0; i < 12; i++) begin
            runCycle(1'b0, 1'b1, (i % 2 == 0), 6, (i % 2 == 0), 1'b1);
        end
        runCycle(1'b0, 1'b1, 1'b1, 5, 1'b0, 1'b0);
        idleCycle();
        checkValue("predValid", sampledPredValid, 1'b1);
        checkValue("predTaken", sampledPredTaken, 1'b1);
        runCycle(1'b0, 1'b1, 1'b1, 6, 1'b1, 1'b1);
        runCycle(1'b0, 1'b1, 1'b1, 5, 1'b0, 1'b0);
        idleCycle();
        checkValue("predTaken", sampledPredTaken, 1'b0); // pattern says not taken next
        reportTest("training and prediction", c0, e0);
    endtask

    task automatic testSaturationConflict();
        int c0;
        int e0;
        c0 = checkCount;
        e0 = errorCount;
        for (int i = 0; i < 8; i++) begin
            runCycle(1'b0, 1'b1, 1'b0, 0, 1'b0, 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            runCycle(1'b0, 1'b1, 1'b1, 0, 1'b1, 1'b1);
        end
        runCycle(1'b0, 1'b1, 1'b1, 7, 1'b0, 1'b0); // redirect to pool pc 0
        idleCycle();
        checkValue("predValid", sampledPredValid, 1'b1);
        checkValue("predTaken", sampledPredTaken, 1'b1);
        runCycle(1'b0, 1'b1, 1'b1, 1, 1'b0, 1'b0); // same index, other tag
        runCycle(1'b0, 1'b1, 1'b1, 7, 1'b0, 1'b0);
        idleCycle();
        checkValue("predValid", sampledPredValid, 1'b0);
        reportTest("saturation and tag conflict", c0, e0);
    endtask

    task automatic testRandom();
        int          c0;
        int          e0;
        logic [31:0] r;
        logic        cp;
        logic        cpv;
        c0 = checkCount;
        e0 = errorCount;
        for (int i = 0; i < 2000; i++) begin
            rngState = xorshift(rngState);
            r = rngState;
            if (r[8]) begin
                cp = sampledPredTaken; // replay last cycle's prediction
                cpv = sampledPredValid;
            end else begin
                cp = r[9];
                cpv = r[10];
            end
            runCycle((r[2:0] == 3'd0), r[3], r[4], int'(r[7:5]), cp, cpv);
        end
        reportTest("long random run", c0, e0);
    endtask

    initial begin
        reset = 1'b0;
        stall = 1'b0;
        resolveBranch = 1'b0;
        resolveTaken = 1'b0;
        resolvePc = '0;
        resolveTarget = '0;
        carriedPred = 1'b0;
        carriedPredValid = 1'b0;
        rngState = 32'ha39d;
        checkCount = 0;
        errorCount = 0;
        testCount = 0;
        sampledPredTaken = 1'b0;
        sampledPredValid = 1'b0;
        clearModel();
        @(posedge clk);
        #5;
        testResetSequential();
        testStall();
        testCorrections();
        testTraining();
        testSaturationConflict();
        testRandom();
        $display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(PLANNED_CYCLES * PERIOD + MARGIN_CYCLES * PERIOD);
        $display("watchdog expired, the tests did not complete in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/predictorPkg.sv
rtl/branchUpdateIf.sv
rtl/lookupIf.sv
rtl/branchResolver.sv
rtl/targetBuffer.sv
rtl/historyTable.sv
rtl/patternTable.sv
rtl/nextPcSelect.sv
rtl/localPredictor.sv
tests/localPredictorTb.sv

// ==== Bender.yml ====
package:
  name: local_predictor

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/predictorPkg.sv
      - rtl/branchUpdateIf.sv
      - rtl/lookupIf.sv
      - rtl/branchResolver.sv
      - rtl/targetBuffer.sv
      - rtl/historyTable.sv
      - rtl/patternTable.sv
      - rtl/nextPcSelect.sv
      - rtl/localPredictor.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/localPredictorTb.sv
